// File: axi_width_pkg.sv
// Shared AXI4 address-channel field types and request structs for the width converter blocks
`default_nettype none

package axi_width_pkg;

    localparam int ID_W   = 4;                       // Transaction id width
    localparam int ADDR_W = 32;                      // Byte address width

    typedef logic [ID_W-1:0]   axi_id_t;             // AxID
    typedef logic [ADDR_W-1:0] axi_addr_t;           // AxADDR
    typedef logic [7:0]        axi_len_t;            // AxLEN, beats minus one
    typedef logic [2:0]        axi_size_t;           // AxSIZE, log2 of bytes per beat
    typedef logic [1:0]        axi_burst_t;          // FIXED / INCR / WRAP
    typedef logic [3:0]        axi_cache_t;          // AxCACHE
    typedef logic [2:0]        axi_prot_t;           // AxPROT
    typedef logic [3:0]        axi_qos_t;            // AxQOS
    typedef logic [13:0]       beat_cnt_t;           // Output beats minus one, up to 256 x 64

    // Address request as seen on either AXI4 port
    typedef struct packed {
        axi_id_t    id;
        axi_addr_t  addr;
        axi_len_t   len;
        axi_size_t  size;
        axi_burst_t burst;
        logic       lock;                            // Exclusive access flag
        axi_cache_t cache;
        axi_prot_t  prot;
        axi_qos_t   qos;
    } axi_addr_req_t;

    // Converted request, beat count may exceed one AXI4 burst
    typedef struct packed {
        axi_id_t    id;
        axi_addr_t  addr;
        beat_cnt_t  beats;                           // Replaces len until the splitter
        axi_size_t  size;
        axi_burst_t burst;
        logic       lock;
        axi_cache_t cache;
        axi_prot_t  prot;
        axi_qos_t   qos;
    } conv_req_t;

    typedef enum logic [0:0] {
        IDLE,                                        // Waiting for a buffered request
        ISSUE                                        // Presenting pieces on the output
    } split_state_t;

endpackage

`default_nettype wire

// File: len_scaler.sv
// Register stage feeding the request FIFO that rescales AXI4 burst length and size to the output width
`default_nettype none

module len_scaler #(
    parameter int IN_BYTES  = 8,                     // Input data bus bytes as a power of two
    parameter int OUT_BYTES = 2                      // Output data bus bytes as a power of two
) (
    input  wire                           clock,
    input  wire                           rst_n,
    input  axi_width_pkg::axi_addr_req_t  in_req,
    input  wire                           in_valid,
    output logic                          in_ready,
    output axi_width_pkg::conv_req_t      out_req,
    output logic                          out_valid,
    input  wire                           out_ready
);

    localparam int IN_LG  = $clog2(IN_BYTES);
    localparam int OUT_LG = $clog2(OUT_BYTES);
    localparam int SHIFT  = (IN_LG >= OUT_LG) ? IN_LG - OUT_LG : OUT_LG - IN_LG;  // log2 of ratio
    localparam int RND    = (1 << SHIFT) - 1;      // Low-bit mask / round-up addend

    axi_width_pkg::beat_cnt_t beats;                 // Converted beats minus one
    axi_width_pkg::conv_req_t conv;                  // Combinational converted request
    logic                     load;                  // Input transfer this cycle

    generate
        if (IN_BYTES >= OUT_BYTES) begin : g_narrow
            // (len+1)*R - 1 with all low bits set
            assign beats = (axi_width_pkg::beat_cnt_t'(in_req.len) << SHIFT)
                         | axi_width_pkg::beat_cnt_t'(RND);
        end else begin : g_widen
            logic [9:0] total_rnd;                   // len+1 plus R-1 stays within 319

            assign total_rnd = 10'(in_req.len) + 10'd1 + 10'(RND);
            // ceil((len+1)/R) - 1
            assign beats = axi_width_pkg::beat_cnt_t'((total_rnd >> SHIFT) - 10'd1);
        end
    endgenerate

    always_comb begin
        conv.id    = in_req.id;
        conv.addr  = in_req.addr;
        conv.beats = beats;
        conv.size  = axi_width_pkg::axi_size_t'(OUT_LG);  // Full-width beats on the output
        conv.burst = in_req.burst;
        conv.lock  = in_req.lock;
        conv.cache = in_req.cache;
        conv.prot  = in_req.prot;
        conv.qos   = in_req.qos;
    end

    assign in_ready = !out_valid || out_ready;       // Empty or draining this cycle
    assign load     = in_valid && in_ready;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (load) begin
            out_valid <= 1'b1;                       // New entry replaces or fills the stage
        end else if (out_ready) begin
            out_valid <= 1'b0;                       // Drained with nothing behind it
        end
    end

    always_ff @(posedge clock) begin
        if (load) begin
            out_req <= conv;                         // Capture the converted request
        end
    end

endmodule

`default_nettype wire

// File: addr_req_fifo.sv
// Circular-buffer FIFO holding converted address requests between the scaler and the splitter
`default_nettype none

module addr_req_fifo #(
    parameter int DEPTH = 4                          // Number of entries
) (
    input  wire                       clock,
    input  wire                       rst_n,
    input  axi_width_pkg::conv_req_t  wr_req,
    input  wire                       wr_valid,
    output logic                      wr_ready,
    output axi_width_pkg::conv_req_t  rd_req,
    output logic                      rd_valid,
    input  wire                       rd_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    axi_width_pkg::conv_req_t mem [DEPTH];           // Entry storage
    logic [PTR_W-1:0]         wr_ptr;                // Next slot to write
    logic [PTR_W-1:0]         rd_ptr;                // Oldest entry
    logic [CNT_W-1:0]         count;                 // Occupancy
    logic                     full;
    logic                     push;
    logic                     pop;

    assign full     = (count == CNT_W'(DEPTH));
    assign rd_valid = (count != '0);
    assign rd_req   = mem[rd_ptr];                   // Oldest entry always presented
    assign wr_ready = !full || rd_ready;             // A read frees the slot when full
    assign push     = wr_valid && wr_ready;
    assign pop      = rd_valid && rd_ready;

    // Wrap for any depth, not only powers of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;             // Both or neither, no change
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= wr_req;                   // Visible at rd_req next cycle
        end
    end

endmodule

`default_nettype wire

// File: burst_splitter.sv
// Issues each converted request as AXI4 bursts of at most 256 beats with advancing addresses
`default_nettype none

module burst_splitter #(
    parameter int OUT_BYTES = 2                      // Output data bus bytes
) (
    input  wire                           clock,
    input  wire                           rst_n,
    input  axi_width_pkg::conv_req_t      in_req,
    input  wire                           in_valid,
    output logic                          in_ready,
    output axi_width_pkg::axi_addr_req_t  out_req,
    output logic                          out_valid,
    input  wire                           out_ready
);

    localparam axi_width_pkg::axi_addr_t STEP = axi_width_pkg::axi_addr_t'(256 * OUT_BYTES);

    axi_width_pkg::split_state_t state;              // Splitter FSM
    axi_width_pkg::beat_cnt_t    rem;                // Remaining beats minus one
    axi_width_pkg::axi_addr_t    cur_addr;           // Start address of current piece
    axi_width_pkg::axi_len_t     piece_len;          // len of current piece
    logic                        last;               // Current piece ends the request

    assign last      = (rem[13:8] == '0);            // 256 beats or fewer remain
    assign piece_len = last ? rem[7:0] : 8'hff;
    assign out_valid = (state == axi_width_pkg::ISSUE);
    // Pop the buffered entry with its last piece
    assign in_ready  = out_valid && last && out_ready;

    always_comb begin
        out_req.id    = in_req.id;                   // Same id on every piece
        out_req.addr  = cur_addr;
        out_req.len   = piece_len;
        out_req.size  = in_req.size;
        out_req.burst = in_req.burst;
        out_req.lock  = in_req.lock;
        out_req.cache = in_req.cache;
        out_req.prot  = in_req.prot;
        out_req.qos   = in_req.qos;
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state    <= axi_width_pkg::IDLE;
            rem      <= '0;
            cur_addr <= '0;
        end else begin
            case (state)
                axi_width_pkg::IDLE: begin
                    if (in_valid) begin
                        rem      <= in_req.beats;    // Entry stays on in_req until popped
                        cur_addr <= in_req.addr;
                        state    <= axi_width_pkg::ISSUE;
                    end
                end
                axi_width_pkg::ISSUE: begin
                    if (out_ready) begin
                        if (last) begin
                            state <= axi_width_pkg::IDLE;
                        end else begin
                            rem      <= rem - 14'd256;   // One full burst consumed
                            cur_addr <= cur_addr + STEP;
                        end
                    end
                end
                default: state <= axi_width_pkg::IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: axi_addr_width_conv.sv
// Top level of the AXI4 address-channel width converter, chaining scaler, FIFO and burst splitter
`default_nettype none

module axi_addr_width_conv #(
    parameter int IN_BYTES   = 8,                    // Master data bus bytes
    parameter int OUT_BYTES  = 2,                    // Slave data bus bytes
    parameter int FIFO_DEPTH = 4                     // Buffered converted requests
) (
    input  wire                           clock,
    input  wire                           rst_n,
    input  axi_width_pkg::axi_addr_req_t  in_req,    // Master-side address channel
    input  wire                           in_valid,
    output logic                          in_ready,
    output axi_width_pkg::axi_addr_req_t  out_req,   // Slave-side address channel
    output logic                          out_valid,
    input  wire                           out_ready
);

    axi_width_pkg::conv_req_t scl_req;               // Scaler to FIFO
    logic                     scl_valid;
    logic                     scl_ready;
    axi_width_pkg::conv_req_t buf_req;               // FIFO to splitter
    logic                     buf_valid;
    logic                     buf_ready;

    len_scaler #(
        .IN_BYTES  (IN_BYTES),
        .OUT_BYTES (OUT_BYTES)
    ) i_len_scaler (
        .clock     (clock),
        .rst_n     (rst_n),
        .in_req    (in_req),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_req   (scl_req),
        .out_valid (scl_valid),
        .out_ready (scl_ready)
    );

    addr_req_fifo #(
        .DEPTH     (FIFO_DEPTH)
    ) i_addr_req_fifo (
        .clock     (clock),
        .rst_n     (rst_n),
        .wr_req    (scl_req),
        .wr_valid  (scl_valid),
        .wr_ready  (scl_ready),
        .rd_req    (buf_req),
        .rd_valid  (buf_valid),
        .rd_ready  (buf_ready)
    );

    burst_splitter #(
        .OUT_BYTES (OUT_BYTES)
    ) i_burst_splitter (
        .clock     (clock),
        .rst_n     (rst_n),
        .in_req    (buf_req),
        .in_valid  (buf_valid),
        .in_ready  (buf_ready),
        .out_req   (out_req),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

`default_nettype wire

// File: axi_addr_width_conv_asserts.sv
// Assertions bound into the width converter top level on its handshake, reset state and output data
`default_nettype none

module axi_addr_width_conv_asserts (
    input wire                               clock,
    input wire                               rst_n,
    input wire                               in_ready,
    input wire axi_width_pkg::axi_addr_req_t out_req,
    input wire                               out_valid,
    input wire                               out_ready
);

    int fail_count = 0;                              // Read by the testbench top

    // Stalled burst keeps valid and payload
    a_out_stable: assert property (@(posedge clock) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_req))
        else begin
            $error("out_valid or out_req changed while out_ready was low");
            fail_count++;
        end

    a_reset_state: assert property (@(posedge clock) $rose(rst_n) |-> !out_valid && in_ready)
        else begin
            $error("out_valid high or in_ready low in the first cycle after reset");
            fail_count++;
        end

    a_no_x: assert property (@(posedge clock) disable iff (!rst_n)
        out_valid |-> !$isunknown(out_req))
        else begin
            $error("Unknown bits on out_req while out_valid is high");
            fail_count++;
        end

endmodule

`default_nettype wire

// File: addr_checker.sv
// Scoreboard that predicts the output bursts of the width converter and compares every output transfer
`default_nettype none

module addr_checker #(
    parameter int IN_BYTES   = 8,
    parameter int OUT_BYTES  = 2,
    parameter int FIFO_DEPTH = 4
) (
    input  wire                               clock,
    input  wire                               rst_n,
    input  wire axi_width_pkg::axi_addr_req_t in_req,
    input  wire                               in_valid,
    input  wire                               in_ready,
    input  wire axi_width_pkg::axi_addr_req_t out_req,
    input  wire                               out_valid,
    input  wire                               out_ready,
    output int                                mismatches,
    output int                                other_errs,
    output int                                pending,       // Bursts still expected
    output int                                out_count
);

    axi_width_pkg::axi_addr_req_t exp_q [$];         // Predicted bursts in order
    int                           stall_in;          // Inputs taken during current stall

    // Total bytes over output width rounded up, then cut into 256-beat pieces
    task automatic predict(input axi_width_pkg::axi_addr_req_t req);
        int unsigned                  beats;
        int unsigned                  k;
        axi_width_pkg::axi_addr_req_t piece;
        beats      = ((int'(req.len) + 1) * IN_BYTES + OUT_BYTES - 1) / OUT_BYTES;
        piece      = req;
        piece.size = axi_width_pkg::axi_size_t'($clog2(OUT_BYTES));
        k          = 0;
        while (beats > 0) begin
            piece.addr = req.addr + axi_width_pkg::axi_addr_t'(k * 256 * OUT_BYTES);
            piece.len  = (beats > 256) ? 8'd255 : axi_width_pkg::axi_len_t'(beats - 1);
            exp_q.push_back(piece);
            beats = (beats > 256) ? beats - 256 : 0;
            k++;
        end
    endtask

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp);
            mismatches++;
        end
    endtask

    initial begin
        mismatches = 0;
        other_errs = 0;
        pending    = 0;
        out_count  = 0;
        stall_in   = 0;
    end

    always @(posedge clock) begin
        axi_width_pkg::axi_addr_req_t exp;
        if (rst_n) begin
            if (in_valid && in_ready) begin
                predict(in_req);
            end
            if (out_ready) begin
                stall_in = 0;                        // Stall over
            end else if (in_valid && in_ready) begin
                stall_in++;
                if (stall_in > FIFO_DEPTH + 1) begin
                    $display("Input accepted %0d requests while out_ready was low", stall_in);
                    other_errs++;
                end
            end
            if (out_valid && out_ready) begin
                out_count++;
                if (exp_q.size() == 0) begin
                    $display("Output burst seen with no request left to match it");
                    other_errs++;
                end else begin
                    exp = exp_q.pop_front();
                    compare_field("out_req.id", 32'(out_req.id), 32'(exp.id));
                    compare_field("out_req.addr", out_req.addr, exp.addr);
                    compare_field("out_req.len", 32'(out_req.len), 32'(exp.len));
                    compare_field("out_req.size", 32'(out_req.size), 32'(exp.size));
                    compare_field("out_req.burst", 32'(out_req.burst), 32'(exp.burst));
                    compare_field("out_req.lock", 32'(out_req.lock), 32'(exp.lock));
                    compare_field("out_req.cache", 32'(out_req.cache), 32'(exp.cache));
                    compare_field("out_req.prot", 32'(out_req.prot), 32'(exp.prot));
                    compare_field("out_req.qos", 32'(out_req.qos), 32'(exp.qos));
                end
            end
            pending = exp_q.size();
        end
    end

endmodule

`default_nettype wire

// File: tb_axi_addr_width_conv.sv
// Testbench top for the AXI4 address width converter, run with 8/2 bytes and again with 2/8 bytes
`default_nettype none

module tb_axi_addr_width_conv #(
    parameter int IN_BYTES  = 8,                     // Master bus bytes
    parameter int OUT_BYTES = 2                      // Slave bus bytes
);

    localparam int FIFO_DEPTH = 4;
    localparam int N_REQ      = 12;
    localparam int MAX_CYCLES = 40 * N_REQ + 200;    // Run limit in clock cycles
    localparam axi_width_pkg::axi_size_t SZ = axi_width_pkg::axi_size_t'($clog2(IN_BYTES));

    typedef struct packed {
        axi_width_pkg::axi_addr_req_t req;
        logic                         stall;         // Hold out_ready low from this row on
        logic [3:0]                   bursts_nar;    // Output bursts with 8 in / 2 out
        logic [3:0]                   bursts_wid;    // Output bursts with 2 in / 8 out
    } stim_t;

    // id, addr, len, size, burst, lock, cache, prot, qos
    stim_t stim [N_REQ] = '{
        '{'{4'h1, 32'h0000_1000, 8'd3,   SZ, 2'b01, 1'b0, 4'h3, 3'h2, 4'h0}, 1'b0, 4'd1, 4'd1},
        '{'{4'h2, 32'h0001_0000, 8'd255, SZ, 2'b01, 1'b0, 4'h2, 3'h0, 4'h5}, 1'b0, 4'd4, 4'd1},
        '{'{4'h3, 32'h0000_2040, 8'd4,   SZ, 2'b01, 1'b1, 4'hf, 3'h7, 4'h9}, 1'b0, 4'd1, 4'd1},
        '{'{4'h4, 32'h0000_3008, 8'd0,   SZ, 2'b00, 1'b0, 4'h0, 3'h1, 4'h1}, 1'b0, 4'd1, 4'd1},
        '{'{4'h5, 32'h0004_0000, 8'd63,  SZ, 2'b01, 1'b0, 4'h6, 3'h3, 4'hf}, 1'b0, 4'd1, 4'd1},
        '{'{4'h6, 32'h0005_0010, 8'd64,  SZ, 2'b01, 1'b1, 4'h7, 3'h4, 4'h2}, 1'b1, 4'd2, 4'd1},
        '{'{4'h7, 32'h0006_0000, 8'd127, SZ, 2'b01, 1'b0, 4'h3, 3'h5, 4'h3}, 1'b0, 4'd2, 4'd1},
        '{'{4'h8, 32'h0000_4004, 8'd7,   SZ, 2'b10, 1'b0, 4'h1, 3'h6, 4'h4}, 1'b0, 4'd1, 4'd1},
        '{'{4'h9, 32'h0007_0000, 8'd128, SZ, 2'b01, 1'b1, 4'hb, 3'h2, 4'h7}, 1'b0, 4'd3, 4'd1},
        '{'{4'ha, 32'h0000_5000, 8'd15,  SZ, 2'b01, 1'b0, 4'h2, 3'h0, 4'h8}, 1'b0, 4'd1, 4'd1},
        '{'{4'hb, 32'h0008_0100, 8'd191, SZ, 2'b01, 1'b0, 4'he, 3'h1, 4'ha}, 1'b0, 4'd3, 4'd1},
        '{'{4'hc, 32'hffff_f000, 8'd1,   SZ, 2'b01, 1'b1, 4'h3, 3'h3, 4'hc}, 1'b0, 4'd1, 4'd1}
    };

    logic                         clock;
    logic                         rst_n;
    axi_width_pkg::axi_addr_req_t in_req;
    logic                         in_valid;
    logic                         in_ready;
    axi_width_pkg::axi_addr_req_t out_req;
    logic                         out_valid;
    logic                         out_ready;
    int                           hold_cycles;       // Forced stall cycles left
    int                           cycles;            // Timeout counter
    int                           tb_errs;
    int                           exp_bursts;        // Bursts expected from the table
    int                           mismatches;
    int                           other_errs;
    int                           pending;
    int                           out_count;

    axi_addr_width_conv #(
        .IN_BYTES   (IN_BYTES),
        .OUT_BYTES  (OUT_BYTES),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_dut (
        .clock      (clock),
        .rst_n      (rst_n),
        .in_req     (in_req),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .out_req    (out_req),
        .out_valid  (out_valid),
        .out_ready  (out_ready)
    );

    addr_checker #(
        .IN_BYTES   (IN_BYTES),
        .OUT_BYTES  (OUT_BYTES),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_checker (
        .clock      (clock),
        .rst_n      (rst_n),
        .in_req     (in_req),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .out_req    (out_req),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .mismatches (mismatches),
        .other_errs (other_errs),
        .pending    (pending),
        .out_count  (out_count)
    );

    bind axi_addr_width_conv axi_addr_width_conv_asserts i_asserts (
        .clock      (clock),
        .rst_n      (rst_n),
        .in_ready   (in_ready),
        .out_req    (out_req),
        .out_valid  (out_valid),
        .out_ready  (out_ready)
    );

    function automatic int expected_bursts(input stim_t row);
        int beats;
        beats = ((int'(row.req.len) + 1) * IN_BYTES + OUT_BYTES - 1) / OUT_BYTES;
        if (IN_BYTES == 8 && OUT_BYTES == 2) begin
            return row.bursts_nar;
        end else if (IN_BYTES == 2 && OUT_BYTES == 8) begin
            return row.bursts_wid;
        end
        return (beats + 255) / 256;                  // Other widths straight from the rule
    endfunction

    task automatic print_counts();
        $display("Error counts: %0d mismatch, %0d checker, %0d assertion, %0d testbench",
                 mismatches, other_errs, i_dut.i_asserts.fail_count, tb_errs);
    endtask

    always #20 clock = ~clock;                       // 40-unit period

    // Random back-pressure, forced low while a stall runs
    always @(posedge clock) begin
        if (hold_cycles != 0) begin
            out_ready   <= 1'b0;
            hold_cycles <= hold_cycles - 1;
        end else if (rst_n) begin
            out_ready <= ($urandom % 4) != 0;        // Ready about 3 cycles in 4
        end
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            print_counts();
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h1af4));
        clock       = 1'b0;
        rst_n       = 1'b0;
        in_req      = '0;
        in_valid    = 1'b0;
        out_ready   = 1'b0;
        hold_cycles = 0;
        cycles      = 0;
        tb_errs     = 0;
        exp_bursts  = 0;
        repeat (3) @(posedge clock);
        rst_n <= 1'b1;
        for (int i = 0; i < N_REQ; i++) begin
            if ($urandom % 3 == 0) begin
                in_valid <= 1'b0;                    // Idle gap between requests
                @(posedge clock);
            end
            if (stim[i].stall) begin
                hold_cycles <= 24;                   // Long enough to fill FIFO and scaler
            end
            in_req     <= stim[i].req;
            in_valid   <= 1'b1;
            exp_bursts += expected_bursts(stim[i]);
            @(posedge clock);
            while (!in_ready) begin
                @(posedge clock);                    // Hold until accepted
            end
        end
        in_valid <= 1'b0;
        do begin
            @(negedge clock);
        end while (pending != 0);
        repeat (10) @(negedge clock);                // Room for stray extra bursts
        if (out_count != exp_bursts) begin
            $display("Wrong number of output bursts: %0d seen, %0d expected",
                     out_count, exp_bursts);
            tb_errs++;
        end
        print_counts();
        if (mismatches + other_errs + tb_errs + i_dut.i_asserts.fail_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
axi_width_pkg.sv
len_scaler.sv
addr_req_fifo.sv
burst_splitter.sv
axi_addr_width_conv.sv
axi_addr_width_conv_asserts.sv
addr_checker.sv
tb_axi_addr_width_conv.sv

// File: Bender.yml
package:
  name: axi_addr_width_conv

sources:
  - axi_width_pkg.sv
  - len_scaler.sv
  - addr_req_fifo.sv
  - burst_splitter.sv
  - axi_addr_width_conv.sv
  - target: test
    files:
      - axi_addr_width_conv_asserts.sv
      - addr_checker.sv
      - tb_axi_addr_width_conv.sv
